/* hdl/ps2_pkg.sv */
package ps2_pkg;

    typedef logic [7:0] ps2_code_t;     // One PS/2 scan code
    typedef logic [6:0] seg_t;          // Segments a..g, MSB is a, active low
    typedef logic [6:0] press_count_t;  // Distinct key events, 0 to 99

    typedef struct packed {
        logic      valid;
        ps2_code_t code;
    } key_event_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_DATA,
        RX_PARITY,
        RX_STOP
    } rx_state_t;

    // Hex font for a common-anode digit; a lit segment is driven low
    function automatic seg_t seg_encode(input logic [3:0] value);
        case (value)
            4'h0:    return 7'b0000001;
            4'h1:    return 7'b1001111;
            4'h2:    return 7'b0010010;
            4'h3:    return 7'b0000110;
            4'h4:    return 7'b1001100;
            4'h5:    return 7'b0100100;
            4'h6:    return 7'b0100000;
            4'h7:    return 7'b0001111;
            4'h8:    return 7'b0000000;
            4'h9:    return 7'b0000100;
            4'hA:    return 7'b0001000;
            4'hB:    return 7'b1100000; // Lower case b
            4'hC:    return 7'b0110001;
            4'hD:    return 7'b1000010; // Lower case d
            4'hE:    return 7'b0110000;
            default: return 7'b0111000;
        endcase
    endfunction

endpackage

/* hdl/ps2_frame_rx.sv */
`timescale 1ns/1ps

module ps2_frame_rx
    import ps2_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    output key_event_t key_event,
    output logic       frame_error
);

    logic      clk_s1;
    logic      clk_s2;
    logic      clk_s3;
    logic      data_s1;
    logic      data_s2;
    logic      fall;
    rx_state_t state;
    logic [2:0] bit_cnt;
    ps2_code_t shift_reg;
    logic      parity_bit;
    logic      event_q;

    // Two-flop synchronizers, plus a third flop on the clock for edge detection
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            clk_s1  <= 1'b1;
            clk_s2  <= 1'b1;
            clk_s3  <= 1'b1;
            data_s1 <= 1'b1;
            data_s2 <= 1'b1;
        end else begin
            clk_s1  <= ps2_clk;
            clk_s2  <= clk_s1;
            clk_s3  <= clk_s2;
            data_s1 <= ps2_data;
            data_s2 <= data_s1;
        end
    end

    assign fall = clk_s3 & ~clk_s2;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= RX_IDLE;
            bit_cnt     <= 3'd0;
            event_q     <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            event_q     <= 1'b0; // Strobes last one cycle
            frame_error <= 1'b0;
            if (fall) begin
                case (state)
                    RX_IDLE: begin
                        if (!data_s2) begin // Start bit
                            state   <= RX_DATA;
                            bit_cnt <= 3'd0;
                        end
                    end
                    RX_DATA: begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state <= RX_PARITY;
                        end
                    end
                    RX_PARITY: begin
                        state <= RX_STOP;
                    end
                    default: begin
                        if (data_s2 && (^{shift_reg, parity_bit})) begin
                            event_q <= 1'b1;
                        end else begin
                            frame_error <= 1'b1;
                        end
                        state <= RX_IDLE;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fall && state == RX_DATA) begin
            shift_reg <= {data_s2, shift_reg[7:1]}; // LSB arrives first
        end
        if (fall && state == RX_PARITY) begin
            parity_bit <= data_s2;
        end
    end

    assign key_event.valid = event_q;
    assign key_event.code  = shift_reg; // Held stable until the next frame's data

endmodule

/* hdl/scan_code_fifo.sv */
`timescale 1ns/1ps

module scan_code_fifo
    import ps2_pkg::*;
#(
    parameter int FIFO_DEPTH = 8
) (
    input  logic       clk,
    input  logic       rst_n,
    input  key_event_t key_event,
    input  logic       next_code,
    output ps2_code_t  code,
    output logic       ready,
    output logic       overflow
);

    localparam int AW = $clog2(FIFO_DEPTH);

    ps2_code_t   mem [FIFO_DEPTH];
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic        empty;
    logic        full;
    logic        push;
    logic        pop;

    assign empty = (wr_ptr == rd_ptr);
    // Same address but different wrap bit means every slot is taken
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign pop  = next_code && !empty;
    assign push = key_event.valid && (!full || pop); // A pop frees the slot in the same cycle

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            overflow <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (key_event.valid && !push) begin
                overflow <= 1'b1; // Sticky until reset
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr[AW-1:0]] <= key_event.code;
        end
    end

    assign code  = mem[rd_ptr[AW-1:0]];
    assign ready = !empty;

endmodule

/* hdl/key_display.sv */
`timescale 1ns/1ps

module key_display
    import ps2_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  key_event_t key_event,
    input  ps2_code_t  code,
    input  logic       ready,
    output seg_t       seg_hex_lo,
    output seg_t       seg_hex_hi,
    output seg_t       seg_cnt_ones,
    output seg_t       seg_cnt_tens
);

    ps2_code_t    last_code;
    logic         last_valid;
    press_count_t press_count;
    logic         new_key;
    logic [3:0]   cnt_tens;
    logic [3:0]   cnt_ones;

    // The first event after reset has nothing to compare against and always counts
    assign new_key = key_event.valid && (!last_valid || key_event.code != last_code);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            last_valid  <= 1'b0;
            press_count <= '0;
        end else begin
            if (key_event.valid) begin
                last_valid <= 1'b1;
            end
            if (new_key) begin
                if (press_count == press_count_t'(99)) begin
                    press_count <= '0;
                end else begin
                    press_count <= press_count + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (key_event.valid) begin
            last_code <= key_event.code;
        end
    end

    // Counter never exceeds 99, so both quotient and remainder fit a nibble
    assign cnt_tens = 4'(press_count / press_count_t'(10));
    assign cnt_ones = 4'(press_count % press_count_t'(10));

    assign seg_cnt_tens = seg_encode(cnt_tens);
    assign seg_cnt_ones = seg_encode(cnt_ones);

    always_comb begin
        if (ready) begin
            seg_hex_lo = seg_encode(code[3:0]);
            seg_hex_hi = seg_encode(code[7:4]);
        end else begin
            seg_hex_lo = '1; // Blank while the FIFO is empty
            seg_hex_hi = '1;
        end
    end

endmodule

/* hdl/ps2_keyboard_top.sv */
`timescale 1ns/1ps

module ps2_keyboard_top
    import ps2_pkg::*;
#(
    parameter int FIFO_DEPTH = 8 // Must be a power of two
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      ps2_clk,
    input  logic      ps2_data,
    input  logic      next_code,
    output ps2_code_t code,
    output logic      ready,
    output logic      overflow,
    output logic      frame_error,
    output seg_t      seg_hex_lo,
    output seg_t      seg_hex_hi,
    output seg_t      seg_cnt_ones,
    output seg_t      seg_cnt_tens
);

    key_event_t key_event;

    ps2_frame_rx i_ps2_frame_rx (
        .clk         (clk),
        .rst_n       (rst_n),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .key_event   (key_event),
        .frame_error (frame_error)
    );

    scan_code_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_scan_code_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .key_event (key_event),
        .next_code (next_code),
        .code      (code),
        .ready     (ready),
        .overflow  (overflow)
    );

    key_display i_key_display (
        .clk          (clk),
        .rst_n        (rst_n),
        .key_event    (key_event),
        .code         (code),
        .ready        (ready),
        .seg_hex_lo   (seg_hex_lo),
        .seg_hex_hi   (seg_hex_hi),
        .seg_cnt_ones (seg_cnt_ones),
        .seg_cnt_tens (seg_cnt_tens)
    );

endmodule

/* test/ps2_keyboard_sva.sv */
`timescale 1ns/1ps

module ps2_keyboard_sva
    import ps2_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input key_event_t key_event,
    input logic       frame_error,
    input logic       overflow,
    input logic       ready,
    input logic       next_code,
    input seg_t       seg_hex_lo,
    input seg_t       seg_hex_hi,
    input rx_state_t  rx_state
);

    a_single_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        !(key_event.valid && frame_error))
        else $error("Key event and frame error strobes are high in the same cycle");

    a_overflow_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        overflow |=> overflow)
        else $error("Overflow flag cleared without a reset");

    a_hex_blank: assert property (@(posedge clk) disable iff (!rst_n)
        !ready |-> (seg_hex_lo == 7'h7F && seg_hex_hi == 7'h7F))
        else $error("Hex digits lit while the FIFO is empty");

    // A pop on an empty FIFO is ignored unless a push lands in the same cycle
    a_empty_pop: assert property (@(posedge clk) disable iff (!rst_n)
        (next_code && !ready && !key_event.valid) |=> !ready)
        else $error("Pop on an empty FIFO changed ready");

    // The strobe and the return to RX_IDLE are registered on the same edge
    a_rx_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (key_event.valid || frame_error) |-> rx_state == RX_IDLE)
        else $error("Receiver not in RX_IDLE after a frame strobe");

endmodule

bind ps2_keyboard_top ps2_keyboard_sva i_ps2_keyboard_sva (
    .clk         (clk),
    .rst_n       (rst_n),
    .key_event   (key_event),
    .frame_error (frame_error),
    .overflow    (overflow),
    .ready       (ready),
    .next_code   (next_code),
    .seg_hex_lo  (seg_hex_lo),
    .seg_hex_hi  (seg_hex_hi),
    .rx_state    (i_ps2_frame_rx.state)
);

/* test/ps2_keyboard_tb.sv */
`timescale 1ns/1ps

module ps2_keyboard_tb
    import ps2_pkg::*;
();

    localparam int HALF_BIT     = 10;  // PS/2 clock half period in clk cycles
    localparam int PRESS_FRAMES = 140;

    logic      clk;
    logic      rst_n;
    logic      ps2_clk;
    logic      ps2_data;
    logic      next_code;
    ps2_code_t code;
    logic      ready;
    logic      overflow;
    logic      frame_error;
    seg_t      seg_hex_lo;
    seg_t      seg_hex_hi;
    seg_t      seg_cnt_ones;
    seg_t      seg_cnt_tens;

    integer    seed;
    string     test_name;
    int        errors;
    int        checks;
    int        test_errors;
    int        tests_run;
    int        tests_failed;
    int        ev_cnt = 0;
    int        err_cnt = 0;
    int        depth;
    ps2_code_t ref_q[$];
    logic      ref_overflow;
    int        ref_count;
    ps2_code_t ref_last;
    logic      ref_last_valid;

    ps2_keyboard_top i_ps2_keyboard_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .ps2_clk      (ps2_clk),
        .ps2_data     (ps2_data),
        .next_code    (next_code),
        .code         (code),
        .ready        (ready),
        .overflow     (overflow),
        .frame_error  (frame_error),
        .seg_hex_lo   (seg_hex_lo),
        .seg_hex_hi   (seg_hex_hi),
        .seg_cnt_ones (seg_cnt_ones),
        .seg_cnt_tens (seg_cnt_tens)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        if (i_ps2_keyboard_top.key_event.valid) ev_cnt <= ev_cnt + 1;
        if (frame_error) err_cnt <= err_cnt + 1;
    end

    task automatic check_equal(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("** Error %s: %s expected %0h, actual %0h",
                     test_name, what, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_errors = 0;
        tests_run++;
    endtask

    task automatic end_test();
        if (test_errors == 0) begin
            $display("Test %s: passed", test_name);
        end else begin
            $display("Test %s: failed with %0d errors", test_name, test_errors);
            tests_failed++;
        end
    endtask

    // Frame is start, eight data bits LSB first, odd parity, stop
    task automatic send_frame(input ps2_code_t c, input logic bad_parity, input logic bad_stop);
        logic [10:0] bits;
        bits = {~bad_stop, (~^c) ^ bad_parity, c, 1'b0};
        @(posedge clk);
        for (int i = 0; i < 11; i++) begin
            ps2_data <= bits[i];
            repeat (HALF_BIT) @(posedge clk);
            ps2_clk <= 1'b0;
            repeat (HALF_BIT) @(posedge clk);
            ps2_clk <= 1'b1;
        end
        ps2_data <= 1'b1;
    endtask

    task automatic model_accept(input ps2_code_t c);
        if (ref_q.size() < depth) begin
            ref_q.push_back(c);
        end else begin
            ref_overflow = 1'b1;
        end
        if (!ref_last_valid || c != ref_last) ref_count = (ref_count + 1) % 100;
        ref_last = c;
        ref_last_valid = 1'b1;
    endtask

    task automatic send_code(input ps2_code_t c, input logic bad_parity, input logic bad_stop);
        int   ev0;
        int   err0;
        int   waited;
        logic good;
        good = !bad_parity && !bad_stop;
        ev0 = ev_cnt;
        err0 = err_cnt;
        send_frame(c, bad_parity, bad_stop);
        waited = 0;
        @(negedge clk);
        while (ev_cnt == ev0 && err_cnt == err0 && waited < 4 * HALF_BIT) begin
            @(negedge clk);
            waited++;
        end
        assert (ev_cnt != ev0 || err_cnt != err0) else begin
            $display("Frame with code %h in test %s got no receiver strobe", c, test_name);
            errors++;
            test_errors++;
        end
        check_equal("key events", good, ev_cnt - ev0);
        check_equal("frame errors", !good, err_cnt - err0);
        if (good) model_accept(c);
        check_equal("overflow", ref_overflow, overflow);
    endtask

    task automatic check_count();
        check_equal("count tens", seg_encode(4'(ref_count / 10)), seg_cnt_tens);
        check_equal("count ones", seg_encode(4'(ref_count % 10)), seg_cnt_ones);
    endtask

    task automatic pulse_next_code();
        @(posedge clk);
        next_code <= 1'b1;
        @(posedge clk);
        next_code <= 1'b0;
        @(negedge clk);
    endtask

    task automatic pop_and_check();
        ps2_code_t expected;
        expected = ref_q.pop_front();
        @(negedge clk);
        check_equal("ready before pop", 1, ready);
        check_equal("code", expected, code);
        pulse_next_code();
    endtask

    initial begin
        ps2_code_t c;
        ps2_code_t kept_code;
        seed = 32'h7475;
        depth = i_ps2_keyboard_top.FIFO_DEPTH;
        rst_n = 1'b0;
        ps2_clk = 1'b1;
        ps2_data = 1'b1;
        next_code = 1'b0;
        ref_overflow = 1'b0;
        ref_count = 0;
        ref_last = '0;
        ref_last_valid = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);

        begin_test("reset");
        check_equal("ready", 0, ready);
        check_equal("overflow", 0, overflow);
        check_equal("frame error", 0, frame_error);
        check_equal("hex low digit", 7'h7F, seg_hex_lo);
        check_equal("hex high digit", 7'h7F, seg_hex_hi);
        check_count();
        end_test();

        begin_test("single_frame");
        c = ps2_code_t'($random(seed));
        send_code(c, 1'b0, 1'b0);
        check_equal("ready", 1, ready);
        check_equal("code", c, code);
        check_equal("hex low digit", seg_encode(c[3:0]), seg_hex_lo);
        check_equal("hex high digit", seg_encode(c[7:4]), seg_hex_hi);
        check_count();
        pop_and_check();
        check_equal("ready after pop", 0, ready);
        end_test();

        begin_test("bad_frames");
        kept_code = code;
        pulse_next_code(); // A pop on the empty FIFO must leave it untouched
        check_equal("ready after empty pop", 0, ready);
        check_equal("code after empty pop", kept_code, code);
        send_code(ps2_code_t'($random(seed)), 1'b1, 1'b0);
        send_code(ps2_code_t'($random(seed)), 1'b0, 1'b1);
        check_equal("ready", 0, ready);
        check_equal("code", kept_code, code);
        check_count();
        end_test();

        begin_test("order");
        repeat (5) send_code(ps2_code_t'($random(seed)), 1'b0, 1'b0);
        while (ref_q.size() > 0) pop_and_check();
        check_equal("ready after drain", 0, ready);
        end_test();

        begin_test("overflow");
        repeat (depth + 1) send_code(ps2_code_t'($random(seed)), 1'b0, 1'b0);
        check_equal("overflow when full", 1, overflow);
        while (ref_q.size() > 0) pop_and_check();
        check_equal("ready after drain", 0, ready);
        check_equal("overflow after drain", 1, overflow);
        end_test();

        begin_test("press_counter");
        for (int i = 0; i < PRESS_FRAMES; i++) begin
            if (i % 4 != 3) c = ps2_code_t'($random(seed)); // Every fourth frame repeats
            send_code(c, 1'b0, 1'b0);
            check_count();
        end
        end_test();

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // Twice the time of every frame the tests send
    initial begin
        int frames;
        frames = 1 + 2 + 5 + (i_ps2_keyboard_top.FIFO_DEPTH + 1) + PRESS_FRAMES;
        #(2 * frames * 22 * HALF_BIT * 8);
        $display("Run timed out before all tests had finished");
        $display("Errors found");
        $finish;
    end

endmodule

/* vlog.f */
hdl/ps2_pkg.sv
hdl/ps2_frame_rx.sv
hdl/scan_code_fifo.sv
hdl/key_display.sv
hdl/ps2_keyboard_top.sv
test/ps2_keyboard_sva.sv
test/ps2_keyboard_tb.sv
